//--- alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int data_width = alu_pkg::data_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  alu_pkg::alu_request_t request,
    output alu_pkg::alu_result_t  z
);

    import alu_pkg::*;

    typedef logic [$clog2(data_width)-1:0] shamt_t;

    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
    shamt_t                  shamt;

    logic [data_width-1:0]   and_res;
    logic [data_width-1:0]   or_res;
    logic [data_width-1:0]   not_res;
    logic [data_width-1:0]   neg_res;
    logic [data_width-1:0]   shl_res;
    logic [data_width-1:0]   shr_res;
    logic [data_width-1:0]   shra_res;
    logic [2*data_width-1:0] rol_wide;
    logic [2*data_width-1:0] ror_wide;
    logic [data_width:0]     add_sum;     // Carry in the top bit
    logic [data_width-1:0]   sub_diff;
    logic [2*data_width-1:0] product;
    logic [data_width-1:0]   quotient;
    logic [data_width-1:0]   remainder;
    logic [2*data_width-1:0] result;
    logic                    is_hi_lo;

    function automatic logic [2*data_width-1:0] zext(input logic [data_width-1:0] v);
        return {{data_width{1'b0}}, v};
    endfunction

    function automatic logic [2*data_width-1:0] sext(input logic [data_width-1:0] v);
        return {{data_width{v[data_width-1]}}, v};
    endfunction

    assign a     = request.operand_a;
    assign b     = request.operand_b;
    assign shamt = b[$bits(shamt_t)-1:0];

    // Logic units
    assign and_res = a & b;
    assign or_res  = a | b;
    assign not_res = ~b;
    assign neg_res = -b;

    // Shifts, rotates take their bits from a doubled copy of A
    assign shl_res  = a << shamt;
    assign shr_res  = a >> shamt;
    assign shra_res = $signed(a) >>> shamt;
    assign rol_wide = {a, a} << shamt;
    assign ror_wide = {a, a} >> shamt;

    // One adder serves signed and unsigned add
    assign add_sum  = {1'b0, a} + {1'b0, b};
    assign sub_diff = a - b;

    booth_multiplier #(
        .data_width (data_width)
    ) u_mul (
        .multiplicand (a),
        .multiplier   (b),
        .product      (product)
    );

    divider #(
        .data_width (data_width)
    ) u_div (
        .dividend  (a),
        .divisor   (b),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_comb begin
        if (request.inc_pc) begin
            result = zext(b + 1'b1);   // PC increment overrides the opcode
        end else begin
            case (request.op)
                op_and:          result = zext(and_res);
                op_or:           result = zext(or_res);
                op_neg:          result = sext(neg_res);
                op_not:          result = zext(not_res);
                op_shl:          result = zext(shl_res);
                op_shr:          result = zext(shr_res);
                op_shra:         result = sext(shra_res);
                op_rol:          result = zext(rol_wide[2*data_width-1:data_width]);
                op_ror:          result = zext(ror_wide[data_width-1:0]);
                op_add:          result = sext(add_sum[data_width-1:0]);
                op_sub:          result = sext(sub_diff);
                op_add_unsigned: result = {{(data_width-1){1'b0}}, add_sum};
                op_mul:          result = product;
                op_div:          result = {remainder, quotient};
                default:         result = '0;
            endcase
        end
    end

    assign is_hi_lo = !request.inc_pc && (request.op == op_mul || request.op == op_div);

    // Z register
    always_ff @(posedge clk) begin
        if (reset) begin
            z.valid <= 1'b0;
        end else begin
            z.valid <= request.valid;
        end

        if (request.valid) begin
            z.to_hi_lo <= is_hi_lo;
            z.dest     <= request.dest;
            z.value    <= result;
        end
    end

endmodule

//--- alu_datapath.f
alu_pkg.sv
register_file.sv
booth_multiplier.sv
divider.sv
alu.sv
result_writeback.sv
alu_datapath.sv
tb_clock_gen.sv
alu_datapath_checker.sv
alu_datapath_tb.sv

//--- alu_datapath.sv
`timescale 1ns/1ps

module alu_datapath #(
    parameter int data_width = alu_pkg::data_width,
    parameter int reg_count  = alu_pkg::reg_count
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  alu_pkg::alu_op_e    op,
    input  logic                inc_pc,
    input  alu_pkg::reg_index_t src_a,
    input  alu_pkg::reg_index_t src_b,
    input  alu_pkg::reg_index_t dest,
    input  logic                load,
    input  alu_pkg::reg_index_t load_dest,
    input  alu_pkg::word_t      load_data,
    output logic                wb_valid,
    output alu_pkg::reg_index_t wb_dest,
    output alu_pkg::word_t      wb_data,
    output alu_pkg::word_t      hi,
    output alu_pkg::word_t      lo
);

    import alu_pkg::*;

    alu_request_t request;
    alu_result_t  z;

    register_file #(
        .data_width (data_width),
        .reg_count  (reg_count)
    ) u_regs (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .op        (op),
        .inc_pc    (inc_pc),
        .src_a     (src_a),
        .src_b     (src_b),
        .dest      (dest),
        .load      (load),
        .load_dest (load_dest),
        .load_data (load_data),
        .wb_valid  (wb_valid),   // Writeback loops back into the registers
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .request   (request)
    );

    alu #(
        .data_width (data_width)
    ) u_alu (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .z       (z)
    );

    result_writeback #(
        .data_width (data_width)
    ) u_wb (
        .clk      (clk),
        .reset    (reset),
        .z        (z),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

//--- alu_datapath_checker.sv
`timescale 1ns/1ps

module alu_datapath_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 issue,
    input alu_pkg::alu_op_e     op,
    input logic                 inc_pc,
    input alu_pkg::reg_index_t  src_a,
    input alu_pkg::reg_index_t  src_b,
    input alu_pkg::reg_index_t  dest,
    input logic                 load,
    input alu_pkg::reg_index_t  load_dest,
    input alu_pkg::word_t       load_data,
    input alu_pkg::alu_result_t z,
    input logic                 wb_valid,
    input alu_pkg::reg_index_t  wb_dest,
    input alu_pkg::word_t       wb_data,
    input alu_pkg::word_t       hi,
    input alu_pkg::word_t       lo
);

    import alu_pkg::*;

    typedef struct packed {
        logic       valid;
        logic       to_hi_lo;
        reg_index_t dest;
        dword_t     value;
    } expect_t;

    int      error_count = 0;
    word_t   shadow [reg_count];
    word_t   shadow_hi;
    word_t   shadow_lo;
    expect_t stage1;
    expect_t stage2;   // Lines up with Z
    expect_t stage3;   // Lines up with the writeback outputs

    function automatic dword_t expected_value(alu_op_e o, logic pc, word_t a, word_t b);
        int    s;
        word_t t;
        s = b[4:0];
        if (pc) return {32'h0, b + 32'd1};
        case (o)
            op_and:  return {32'h0, a & b};
            op_or:   return {32'h0, a | b};
            op_not:  return {32'h0, ~b};
            op_neg: begin
                t = 32'd0 - b;
                return {{32{t[31]}}, t};
            end
            op_shl:  return {32'h0, a << s};
            op_shr:  return {32'h0, a >> s};
            op_shra: begin
                t = $signed(a) >>> s;
                return {{32{t[31]}}, t};
            end
            op_rol:  return {32'h0, (a << s) | (a >> (32 - s))};
            op_ror:  return {32'h0, (a >> s) | (a << (32 - s))};
            op_add: begin
                t = a + b;
                return {{32{t[31]}}, t};
            end
            op_sub: begin
                t = a - b;
                return {{32{t[31]}}, t};
            end
            op_add_unsigned: return {32'h0, a} + {32'h0, b};   // Carry lands in bit 32
            op_mul: return {{32{a[31]}}, a} * {{32{b[31]}}, b};
            op_div: begin
                if (b == 32'd0) return {a, 32'hffff_ffff};
                return {word_t'($signed(a) % $signed(b)), word_t'($signed(a) / $signed(b))};
            end
            default: return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                shadow[i] <= '0;
            end
            shadow_hi <= '0;
            shadow_lo <= '0;
            stage1    <= '0;
            stage2    <= '0;
            stage3    <= '0;
        end else begin
            stage1.valid    <= issue;
            stage1.to_hi_lo <= !inc_pc && (op == op_mul || op == op_div);
            stage1.dest     <= dest;
            stage1.value    <= expected_value(op, inc_pc, shadow[src_a], shadow[src_b]);
            stage2 <= stage1;
            stage3 <= stage2;
            if (stage2.valid && stage2.to_hi_lo) begin
                shadow_hi <= stage2.value[63:32];
                shadow_lo <= stage2.value[31:0];
            end
            if (stage3.valid && !stage3.to_hi_lo) begin
                shadow[stage3.dest] <= stage3.value[31:0];
            end else if (load) begin
                shadow[load_dest] <= load_data;   // Writeback wins
            end
        end
    end

    // Upper half of a register result shows only in Z
    z_ok: assert property (@(posedge clk) disable iff (reset)
        stage2.valid |-> z.value == stage2.value)
        else begin
            error_count++;
            $error("Mismatch z.value expected %h actual %h", stage2.value, z.value);
        end

    wb_fires: assert property (@(posedge clk) disable iff (reset)
        stage3.valid && !stage3.to_hi_lo |-> wb_valid)
        else begin
            error_count++;
            $error("Register write expected but wb_valid stayed low");
        end

    wb_quiet: assert property (@(posedge clk) disable iff (reset)
        !(stage3.valid && !stage3.to_hi_lo) |-> !wb_valid)
        else begin
            error_count++;
            $error("wb_valid rose without a register result due");
        end

    dest_ok: assert property (@(posedge clk) disable iff (reset)
        stage3.valid && !stage3.to_hi_lo |-> wb_dest == stage3.dest)
        else begin
            error_count++;
            $error("Mismatch wb_dest expected %h actual %h", stage3.dest, wb_dest);
        end

    data_ok: assert property (@(posedge clk) disable iff (reset)
        stage3.valid && !stage3.to_hi_lo |-> wb_data == stage3.value[31:0])
        else begin
            error_count++;
            $error("Mismatch wb_data expected %h actual %h", stage3.value[31:0], wb_data);
        end

    hi_ok: assert property (@(posedge clk) disable iff (reset) hi == shadow_hi)
        else begin
            error_count++;
            $error("Mismatch hi expected %h actual %h", shadow_hi, hi);
        end

    lo_ok: assert property (@(posedge clk) disable iff (reset) lo == shadow_lo)
        else begin
            error_count++;
            $error("Mismatch lo expected %h actual %h", shadow_lo, lo);
        end

endmodule

bind alu_datapath alu_datapath_checker u_checker (.*);

//--- alu_datapath_tb.sv
`timescale 1ns/1ps

module alu_datapath_tb;

    import alu_pkg::*;

    localparam int stim_cycles = 700;   // Estimated length of all tests
    localparam int cycle_limit = 2 * stim_cycles + 50;

    logic       clk;
    logic       reset;
    logic       issue;
    alu_op_e    op;
    logic       inc_pc;
    reg_index_t src_a;
    reg_index_t src_b;
    reg_index_t dest;
    logic       load;
    reg_index_t load_dest;
    word_t      load_data;
    logic       wb_valid;
    reg_index_t wb_dest;
    word_t      wb_data;
    word_t      hi;
    word_t      lo;
    int         cycles = 0;

    alu_op_e op_list [14] = '{op_and, op_or, op_neg, op_not, op_rol, op_ror, op_shl,
                              op_shra, op_shr, op_add, op_sub, op_add_unsigned,
                              op_mul, op_div};

    tb_clock_gen #(.period_ns(40), .reset_cycles(4)) u_clock (.clk(clk), .reset(reset));

    alu_datapath #(.data_width(data_width), .reg_count(reg_count)) dut (.*);

    task automatic send_cmd(alu_op_e o, logic pc, reg_index_t a, reg_index_t b, reg_index_t d);
        @(negedge clk);
        issue  = 1'b1;
        load   = 1'b0;
        op     = o;
        inc_pc = pc;
        src_a  = a;
        src_b  = b;
        dest   = d;
    endtask

    task automatic load_reg(reg_index_t d, word_t data);
        @(negedge clk);
        issue     = 1'b0;
        load      = 1'b1;
        load_dest = d;
        load_data = data;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            issue = 1'b0;
            load  = 1'b0;
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        issue = 1'b0;
        op = op_add;
        inc_pc = 1'b0;
        src_a = '0;
        src_b = '0;
        dest = '0;
        load = 1'b0;
        load_dest = '0;
        load_data = '0;
        void'($urandom(32'h9271_024f));
        @(negedge reset);
        idle(3);   // HI, LO and wb_valid watched from reset on
        for (int r = 0; r < reg_count; r++) load_reg(r, $urandom);
        idle(1);

        // Logic, shift and rotate over every amount
        for (int s = 0; s < 32; s++) begin
            load_reg(1, $urandom);
            load_reg(2, ($urandom & 32'hffff_ffe0) | s);
            send_cmd(op_shl, 0, 1, 2, 8);
            send_cmd(op_shr, 0, 1, 2, 9);
            send_cmd(op_shra, 0, 1, 2, 10);
            send_cmd(op_rol, 0, 1, 2, 11);
            send_cmd(op_ror, 0, 1, 2, 12);
            send_cmd(op_and, 0, 1, 2, 13);
            send_cmd(op_or, 0, 1, 2, 14);
            idle(4);
        end

        // Arithmetic, with carry out and a dependent read
        for (int i = 0; i < 8; i++) begin
            load_reg(3, (i < 4) ? (32'hffff_0000 | $urandom) : $urandom);
            load_reg(4, (i < 4) ? (32'hffff_0000 | $urandom) : $urandom);
            send_cmd(op_add, 0, 3, 4, 8);
            send_cmd(op_sub, 0, 3, 4, 9);
            send_cmd(op_add_unsigned, 0, 3, 4, 10);
            send_cmd(op_neg, 0, 3, 4, 11);
            idle(4);
            send_cmd(op_add, 0, 8, 10, 12);
            idle(4);
        end

        // Multiply and divide with negatives and a zero divisor
        for (int i = 0; i < 6; i++) begin
            load_reg(5, (i == 1 || i == 3) ? -($urandom & 32'h0fff_ffff) : $urandom);
            load_reg(6, (i == 4) ? 32'd0 : ((i >= 2) ? -($urandom & 32'hffff) : $urandom));
            send_cmd(op_mul, 0, 5, 6, 8);
            idle(2);
            send_cmd(op_div, 0, 5, 6, 9);
            idle(4);
        end

        // PC increment override and an undefined opcode
        send_cmd(op_mul, 1, 5, 6, 8);
        send_cmd(op_div, 1, 6, 5, 9);
        send_cmd(op_and, 1, 3, 7, 10);
        send_cmd(alu_op_e'(5'b00000), 0, 3, 4, 11);
        send_cmd(alu_op_e'(5'b11000), 0, 3, 4, 12);
        idle(4);

        // Back to back random commands
        for (int i = 0; i < 40; i++) begin
            send_cmd(op_list[$urandom_range(13, 0)], ($urandom_range(7, 0) == 0),
                     $urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 8));
        end
        idle(6);

        $display("Run finished after %0d cycles with %0d errors", cycles,
                 dut.u_checker.error_count);
        if (dut.u_checker.error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- alu_pkg.sv
package alu_pkg;

    parameter int data_width = 32;
    parameter int reg_count  = 16;

    typedef logic [data_width-1:0]         word_t;
    typedef logic [2*data_width-1:0]       dword_t;   // ALU result, HI in the upper half
    typedef logic [$clog2(reg_count)-1:0]  reg_index_t;

    // Opcode encodings of the teaching processor
    typedef enum logic [4:0] {
        op_add          = 5'b00011,
        op_sub          = 5'b00100,
        op_shr          = 5'b00101,
        op_shra         = 5'b00110,
        op_shl          = 5'b00111,
        op_ror          = 5'b01000,
        op_rol          = 5'b01001,
        op_or           = 5'b01010,
        op_and          = 5'b01011,
        op_mul          = 5'b01111,
        op_div          = 5'b10000,
        op_neg          = 5'b10001,
        op_not          = 5'b10010,
        op_add_unsigned = 5'b11111
    } alu_op_e;

    // One command leaving the operand stage
    typedef struct packed {
        logic       valid;
        alu_op_e    op;
        logic       inc_pc;
        word_t      operand_a;
        word_t      operand_b;
        reg_index_t dest;
    } alu_request_t;

    // Contents of the Z register
    typedef struct packed {
        logic       valid;
        logic       to_hi_lo;   // Multiply and divide go to HI/LO
        reg_index_t dest;
        dword_t     value;
    } alu_result_t;

endpackage

//--- booth_multiplier.sv
`timescale 1ns/1ps

module booth_multiplier #(
    parameter int data_width = alu_pkg::data_width
) (
    input  alu_pkg::word_t  multiplicand,
    input  alu_pkg::word_t  multiplier,
    output alu_pkg::dword_t product
);

    import alu_pkg::*;

    localparam int pp_count = data_width / 2;   // One partial product per bit pair

    logic [data_width:0]     booth_bits;        // Multiplier with an implied zero below bit 0
    logic [2*data_width-1:0] m_ext;
    logic [2*data_width-1:0] pp [pp_count];

    assign booth_bits = {multiplier, 1'b0};
    assign m_ext      = {{data_width{multiplicand[data_width-1]}}, multiplicand};

    // Recode each overlapping triple into 0, +-M or +-2M
    always_comb begin
        logic [2:0] triple;
        for (int i = 0; i < pp_count; i++) begin
            triple = booth_bits[2*i +: 3];
            case (triple)
                3'b001, 3'b010: pp[i] = m_ext;
                3'b011:         pp[i] = m_ext << 1;
                3'b100:         pp[i] = -(m_ext << 1);
                3'b101, 3'b110: pp[i] = -m_ext;
                default:        pp[i] = '0;       // 000 and 111
            endcase
        end
    end

    // Weighted sum, wraps at the double width
    always_comb begin
        logic [2*data_width-1:0] acc;
        acc = '0;
        for (int i = 0; i < pp_count; i++) begin
            acc = acc + (pp[i] << (2*i));
        end
        product = acc;
    end

endmodule

//--- divider.sv
`timescale 1ns/1ps

module divider #(
    parameter int data_width = alu_pkg::data_width
) (
    input  alu_pkg::word_t dividend,
    input  alu_pkg::word_t divisor,
    output alu_pkg::word_t quotient,
    output alu_pkg::word_t remainder
);

    import alu_pkg::*;

    logic                  neg_a;
    logic                  neg_b;
    logic [data_width-1:0] mag_a;
    logic [data_width-1:0] mag_b;
    logic [data_width-1:0] mag_q;
    logic [data_width-1:0] mag_r;

    assign neg_a = dividend[data_width-1];
    assign neg_b = divisor[data_width-1];
    assign mag_a = neg_a ? -dividend : dividend;
    assign mag_b = neg_b ? -divisor : divisor;

    // Unrolled restoring division on the magnitudes
    always_comb begin
        logic [data_width:0] rem;
        logic [data_width:0] trial;
        rem   = '0;
        mag_q = '0;
        for (int i = data_width - 1; i >= 0; i--) begin
            rem   = {rem[data_width-1:0], mag_a[i]};
            trial = rem - {1'b0, mag_b};
            if (!trial[data_width]) begin     // No borrow, keep the difference
                rem      = trial;
                mag_q[i] = 1'b1;
            end
        end
        mag_r = rem[data_width-1:0];
    end

    // Truncate toward zero, remainder follows the dividend
    assign quotient  = (divisor == '0) ? '1 : ((neg_a ^ neg_b) ? -mag_q : mag_q);
    assign remainder = (divisor == '0) ? dividend : (neg_a ? -mag_r : mag_r);

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int data_width = alu_pkg::data_width,
    parameter int reg_count  = alu_pkg::reg_count
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  alu_pkg::alu_op_e     op,
    input  logic                 inc_pc,
    input  alu_pkg::reg_index_t  src_a,
    input  alu_pkg::reg_index_t  src_b,
    input  alu_pkg::reg_index_t  dest,
    input  logic                 load,
    input  alu_pkg::reg_index_t  load_dest,
    input  alu_pkg::word_t       load_data,
    input  logic                 wb_valid,
    input  alu_pkg::reg_index_t  wb_dest,
    input  alu_pkg::word_t       wb_data,
    output alu_pkg::alu_request_t request
);

    import alu_pkg::*;

    logic [data_width-1:0] regs [reg_count];

    // General registers, writeback beats a direct load
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_dest] <= wb_data;
        end else if (load) begin
            regs[load_dest] <= load_data;
        end
    end

    // Operand stage
    // Sources come straight from the stored values, a write in flight is not seen
    always_ff @(posedge clk) begin
        if (reset) begin
            request.valid <= 1'b0;
        end else begin
            request.valid <= issue;
        end

        if (issue) begin
            request.op        <= op;
            request.inc_pc    <= inc_pc;
            request.operand_a <= regs[src_a];
            request.operand_b <= regs[src_b];
            request.dest      <= dest;
        end
    end

endmodule

//--- result_writeback.sv
`timescale 1ns/1ps

module result_writeback #(
    parameter int data_width = alu_pkg::data_width
) (
    input  logic                 clk,
    input  logic                 reset,
    input  alu_pkg::alu_result_t z,
    output logic                 wb_valid,
    output alu_pkg::reg_index_t  wb_dest,
    output alu_pkg::word_t       wb_data,
    output alu_pkg::word_t       hi,
    output alu_pkg::word_t       lo
);

    import alu_pkg::*;

    logic [data_width-1:0] z_high;
    logic [data_width-1:0] z_low;
    logic                  to_regs;
    logic                  to_hi_lo;

    assign z_high   = z.value[2*data_width-1:data_width];
    assign z_low    = z.value[data_width-1:0];
    assign to_regs  = z.valid && !z.to_hi_lo;
    assign to_hi_lo = z.valid && z.to_hi_lo;

    // Register write port, one cycle per result
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= to_regs;
        end

        if (to_regs) begin
            wb_dest <= z.dest;
            wb_data <= z_low;
        end
    end

    // HI and LO for multiply and divide
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (to_hi_lo) begin
            hi <= z_high;   // Product high word or remainder
            lo <= z_low;    // Product low word or quotient
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f alu_datapath.f \
        --top-module alu_datapath_tb -o alu_datapath_sim; then
    echo "Compile failed"
    exit 1
fi

if ! ./obj_dir/alu_datapath_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
exit 1

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial clk = 1'b0;
    always #(period_ns / 2) clk = ~clk;

    // Reset released on a falling edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
